/* Bender.yml */
package:
  name: cdc_fifo

sources:
  # Package first, the RTL modules import it
  - rtl/cdc_fifo_pkg.sv
  - rtl/cdc_fifo_gray_count_sync.sv
  - rtl/cdc_fifo_push_ctrl.sv
  - rtl/cdc_fifo_pop_ctrl.sv
  - rtl/cdc_fifo_ram_1r1w.sv
  - rtl/cdc_fifo_ctrl_1r1w.sv
  - rtl/cdc_fifo.sv

  - target: test
    files:
      - bench/tb_cdc_fifo.sv

/* bench/tb_cdc_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cdc_fifo;

  import cdc_fifo_pkg::*;

  localparam time PushPeriod = 100;
  localparam time PopPeriod  = 130;
  localparam int  RandWords  = 300;
  localparam int  TotalWords = Depth + RandWords;
  // Each word gets 20 pop periods, far above the worst crossing latency
  localparam time WatchdogTime = TotalWords * 20 * PopPeriod + 10 * PushPeriod;

  logic                  push_clk;
  logic                  pop_clk;
  logic                  arst_n;
  logic                  push_valid;
  logic [Width-1:0]      push_data;
  logic                  push_ready;
  logic                  push_full;
  logic [CountWidth-1:0] push_slots;
  logic                  pop_ready;
  logic                  pop_valid;
  logic [Width-1:0]      pop_data;
  logic                  pop_empty;
  logic [CountWidth-1:0] pop_items;

  // Queue model, filled on every push handshake
  logic [Width-1:0] model_q[$];

  int errors     = 0;
  int checks     = 0;
  int push_count = 0;
  int pop_count  = 0;
  int test_start = 0;

  cdc_fifo DUT (
    .push_clk  (push_clk),
    .pop_clk   (pop_clk),
    .arst_n    (arst_n),
    .push_valid(push_valid),
    .push_data (push_data),
    .push_ready(push_ready),
    .push_full (push_full),
    .push_slots(push_slots),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .pop_empty (pop_empty),
    .pop_items (pop_items)
  );

  // ----------------------------------------
  // Clocks and watchdog
  // ----------------------------------------
  // Periods 100 and 130 never put the two rising edges on the same instant
  initial begin
    push_clk = 1'b0;
    pop_clk  = 1'b0;
  end

  always #(PushPeriod / 2) push_clk = ~push_clk;
  always #(PopPeriod / 2) pop_clk = ~pop_clk;

  initial begin
    #(WatchdogTime);
    $display("Timeout: the run did not finish within %0t", WatchdogTime);
    $display("Done: errors found");
    $finish;
  end

  // ----------------------------------------
  // Reference model and compare
  // ----------------------------------------
  // The oldest word still in the model is the next one the FIFO must return
  function automatic logic [Width-1:0] expected_pop();
    return model_q[0];
  endfunction

  always @(posedge push_clk) begin
    if (push_valid && push_ready) begin
      model_q.push_back(push_data);
      push_count++;
    end
  end

  always @(posedge pop_clk) begin : compare_pop
    logic [Width-1:0] expected;
    if (pop_valid && pop_ready) begin
      checks++;
      if (model_q.size() == 0) begin
        errors++;
        $display("Extra word popped at %0t with nothing left to expect", $time);
      end else begin
        expected = expected_pop();
        if (pop_data !== expected) begin
          errors++;
          $display("[FAIL] pop_data: expected 0x%h, got 0x%h", expected, pop_data);
        end
        model_q.delete(0);
      end
      pop_count++;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name);
    if (errors == test_start) begin
      $display("%s: PASS", name);
    end else begin
      $display("%s: FAIL with %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  // Flags of an empty FIFO with settled counts
  task automatic check_idle_flags();
    check_value("pop_valid", pop_valid, 1'b0);
    check_value("pop_empty", pop_empty, 1'b1);
    check_value("pop_items", pop_items, 0);
    check_value("push_full", push_full, 1'b0);
    check_value("push_slots", push_slots, Depth);
  endtask

  // Called right after a falling push edge, returns after the next one
  task automatic push_word(input logic [Width-1:0] data);
    int waited;
    waited     = 0;
    push_valid = 1'b1;
    push_data  = data;
    do begin
      @(posedge push_clk);
      waited++;
    end while (!push_ready && waited < 40);
    if (!push_ready) begin
      errors++;
      $display("Push of word %0d was not accepted within 40 push cycles", push_count);
    end
    @(negedge push_clk);
    push_valid = 1'b0;
  endtask

  // Both counts cross back after the last pop, then the FIFO reads as empty
  task automatic wait_drained();
    int waited;
    waited = 0;
    while (!(pop_empty && pop_items == 0 && push_slots == Depth) && waited < 40) begin
      @(posedge push_clk);
      waited++;
    end
    check_value("pop_empty", pop_empty, 1'b1);
    check_value("pop_items", pop_items, 0);
    check_value("push_slots", push_slots, Depth);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : run_tests
    int  waited;
    bit  ready_seen;
    void'($urandom(32'ha7f1709b));
    arst_n     = 1'b0;
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;

    // Test 1, flags while reset is held and after it is released
    repeat (5) @(negedge push_clk);
    check_idle_flags();
    check_value("push_ready", push_ready, 1'b0);
    repeat (5) @(negedge push_clk);
    arst_n = 1'b1;
    @(posedge push_clk);
    check_idle_flags();
    waited = 0;
    while (!push_ready && waited < 20) begin
      @(posedge push_clk);
      waited++;
    end
    if (!push_ready) begin
      errors++;
      $display("push_ready did not rise within 20 push cycles after reset");
    end
    check_idle_flags();
    report_test("Test 1 reset state");

    // Test 2, fill with pop_ready held low
    @(negedge push_clk);
    for (int i = 0; i < Depth; i++) begin
      push_word($urandom);
    end
    ready_seen = 1'b0;
    repeat (10) begin
      @(posedge push_clk);
      ready_seen = ready_seen | push_ready;
    end
    check_value("push_ready", ready_seen, 1'b0);
    check_value("push_full", push_full, 1'b1);
    check_value("push_slots", push_slots, 0);
    check_value("accepted words", push_count, Depth);
    waited = 0;
    while (!(pop_items == Depth && pop_valid) && waited < 20) begin
      @(posedge pop_clk);
      waited++;
    end
    check_value("pop_items", pop_items, Depth);
    check_value("pop_valid", pop_valid, 1'b1);
    report_test("Test 2 fill under back-pressure");

    // Test 3, drain and compare every word in push order
    @(negedge pop_clk);
    pop_ready = 1'b1;
    waited    = 0;
    while (pop_count < Depth && waited < 20 * Depth) begin
      @(posedge pop_clk);
      waited++;
    end
    if (pop_count < Depth) begin
      errors++;
      $display("Only %0d of %0d words came out of the full FIFO", pop_count, Depth);
    end
    report_test("Test 3 order and data");

    // Test 4, the FIFO must read as empty and stay quiet
    wait_drained();
    repeat (5) @(posedge pop_clk);
    check_value("pop_valid", pop_valid, 1'b0);
    check_value("model words left", model_q.size(), 0);
    report_test("Test 4 drain to empty");

    // Test 5, random gaps on the push side and random back-pressure on the pop side
    fork
      begin
        @(negedge push_clk);
        for (int i = 0; i < RandWords; i++) begin
          repeat ($urandom_range(0, 2)) @(negedge push_clk);
          push_word($urandom);
        end
      end
      begin
        while (pop_count < TotalWords) begin
          @(negedge pop_clk);
          pop_ready = ($urandom_range(0, 1) == 1);
        end
      end
    join
    wait_drained();
    check_value("model words left", model_q.size(), 0);
    check_value("pushed words", push_count, TotalWords);
    check_value("popped words", pop_count, TotalWords);
    report_test("Test 5 random traffic");

    $display("Summary: %0d checks, %0d errors, %0d words pushed, %0d words popped",
             checks, errors, push_count, pop_count);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_cdc_fifo

`default_nettype wire

/* compile.f */
rtl/cdc_fifo_pkg.sv
rtl/cdc_fifo_gray_count_sync.sv
rtl/cdc_fifo_push_ctrl.sv
rtl/cdc_fifo_pop_ctrl.sv
rtl/cdc_fifo_ram_1r1w.sv
rtl/cdc_fifo_ctrl_1r1w.sv
rtl/cdc_fifo.sv
bench/tb_cdc_fifo.sv

/* rtl/cdc_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo #(
  parameter int NumSyncStages  = 2,
  parameter int RamReadLatency = 1
) (
  input  logic                                push_clk,
  input  logic                                pop_clk,
  input  logic                                arst_n,

  // Push interface, push_clk domain
  input  logic                                push_valid,
  input  logic [cdc_fifo_pkg::Width-1:0]      push_data,
  output logic                                push_ready,
  output logic                                push_full,
  output logic [cdc_fifo_pkg::CountWidth-1:0] push_slots,

  // Pop interface, pop_clk domain
  input  logic                                pop_ready,
  output logic                                pop_valid,
  output logic [cdc_fifo_pkg::Width-1:0]      pop_data,
  output logic                                pop_empty,
  output logic [cdc_fifo_pkg::CountWidth-1:0] pop_items
);

  import cdc_fifo_pkg::*;

  // Controller to RAM bundles
  ram_wr_t     ram_wr;
  ram_rd_req_t ram_rd_req;
  ram_rd_rsp_t ram_rd_rsp;

  cdc_fifo_ctrl_1r1w #(
    .NumSyncStages (NumSyncStages),
    .RamReadLatency(RamReadLatency)
  ) u_ctrl (
    .push_clk  (push_clk),
    .pop_clk   (pop_clk),
    .arst_n    (arst_n),
    .push_valid(push_valid),
    .push_data (push_data),
    .push_ready(push_ready),
    .push_full (push_full),
    .push_slots(push_slots),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .pop_empty (pop_empty),
    .pop_items (pop_items),
    .ram_wr    (ram_wr),
    .ram_rd_req(ram_rd_req),
    .ram_rd_rsp(ram_rd_rsp)
  );

  // Write side runs on push_clk, read side on pop_clk
  cdc_fifo_ram_1r1w #(
    .ReadLatency(RamReadLatency)
  ) u_ram (
    .wr_clk    (push_clk),
    .rd_clk    (pop_clk),
    .arst_n    (arst_n),
    .ram_wr    (ram_wr),
    .ram_rd_req(ram_rd_req),
    .ram_rd_rsp(ram_rd_rsp)
  );

endmodule : cdc_fifo

`default_nettype wire

/* rtl/cdc_fifo_ctrl_1r1w.sv */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_ctrl_1r1w #(
  parameter int NumSyncStages  = 2,
  parameter int RamReadLatency = 1
) (
  input  logic                                push_clk,
  input  logic                                pop_clk,
  input  logic                                arst_n,

  // Push side
  input  logic                                push_valid,
  input  logic [cdc_fifo_pkg::Width-1:0]      push_data,
  output logic                                push_ready,
  output logic                                push_full,
  output logic [cdc_fifo_pkg::CountWidth-1:0] push_slots,

  // Pop side
  input  logic                                pop_ready,
  output logic                                pop_valid,
  output logic [cdc_fifo_pkg::Width-1:0]      pop_data,
  output logic                                pop_empty,
  output logic [cdc_fifo_pkg::CountWidth-1:0] pop_items,

  // RAM ports
  output cdc_fifo_pkg::ram_wr_t               ram_wr,
  output cdc_fifo_pkg::ram_rd_req_t           ram_rd_req,
  input  cdc_fifo_pkg::ram_rd_rsp_t           ram_rd_rsp
);

  import cdc_fifo_pkg::*;

  // Per-domain reset release chains and their outputs
  logic [1:0] push_rst_q;
  logic [1:0] pop_rst_q;
  logic       push_arst_n;
  logic       pop_arst_n;

  // Gray counts, named by the domain they are in
  logic [CountWidth-1:0] push_push_count_gray;
  logic [CountWidth-1:0] pop_push_count_gray;
  logic [CountWidth-1:0] pop_pop_count_gray;
  logic [CountWidth-1:0] push_pop_count_gray;

  // ----------------------------------------
  // Reset release
  // ----------------------------------------
  // Reset enters both domains at once and leaves each on its own clock
  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      push_rst_q <= 2'b00;
    end else begin
      push_rst_q <= {push_rst_q[0], 1'b1};
    end
  end

  always_ff @(posedge pop_clk or negedge arst_n) begin
    if (!arst_n) begin
      pop_rst_q <= 2'b00;
    end else begin
      pop_rst_q <= {pop_rst_q[0], 1'b1};
    end
  end

  assign push_arst_n = push_rst_q[1];
  assign pop_arst_n  = pop_rst_q[1];

  // ----------------------------------------
  // Domain controllers and crossings
  // ----------------------------------------
  cdc_fifo_push_ctrl u_push_ctrl (
    .push_clk       (push_clk),
    .arst_n         (push_arst_n),
    .push_valid     (push_valid),
    .push_data      (push_data),
    .push_ready     (push_ready),
    .push_full      (push_full),
    .push_slots     (push_slots),
    .ram_wr         (ram_wr),
    .push_count_gray(push_push_count_gray),
    .pop_count_gray (push_pop_count_gray)
  );

  // Push count into the pop domain, so the pop side knows what it may read
  cdc_fifo_gray_count_sync #(
    .NumStages(NumSyncStages)
  ) u_sync_push2pop (
    .src_clk       (push_clk),
    .src_arst_n    (push_arst_n),
    .src_count_gray(push_push_count_gray),
    .dst_clk       (pop_clk),
    .dst_arst_n    (pop_arst_n),
    .dst_count_gray(pop_push_count_gray)
  );

  // Pop count into the push domain, so freed slots reach the push side
  cdc_fifo_gray_count_sync #(
    .NumStages(NumSyncStages)
  ) u_sync_pop2push (
    .src_clk       (pop_clk),
    .src_arst_n    (pop_arst_n),
    .src_count_gray(pop_pop_count_gray),
    .dst_clk       (push_clk),
    .dst_arst_n    (push_arst_n),
    .dst_count_gray(push_pop_count_gray)
  );

  cdc_fifo_pop_ctrl #(
    .RamReadLatency(RamReadLatency)
  ) u_pop_ctrl (
    .pop_clk        (pop_clk),
    .arst_n         (pop_arst_n),
    .pop_ready      (pop_ready),
    .pop_valid      (pop_valid),
    .pop_data       (pop_data),
    .pop_empty      (pop_empty),
    .pop_items      (pop_items),
    .ram_rd_req     (ram_rd_req),
    .ram_rd_rsp     (ram_rd_rsp),
    .push_count_gray(pop_push_count_gray),
    .pop_count_gray (pop_pop_count_gray)
  );

endmodule : cdc_fifo_ctrl_1r1w

`default_nettype wire

/* rtl/cdc_fifo_gray_count_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_gray_count_sync #(
  parameter int NumStages = 2
) (
  input  logic                                src_clk,
  input  logic                                src_arst_n,
  input  logic [cdc_fifo_pkg::CountWidth-1:0] src_count_gray,
  input  logic                                dst_clk,
  input  logic                                dst_arst_n,
  output logic [cdc_fifo_pkg::CountWidth-1:0] dst_count_gray
);

  import cdc_fifo_pkg::*;

  // Source flop, so the crossing sees a glitch-free word
  logic [CountWidth-1:0] src_gray_q;

  // Destination chain, stage 0 is the one that may go metastable
  logic [NumStages-1:0][CountWidth-1:0] sync_q;

  // ----------------------------------------
  // Source domain
  // ----------------------------------------
  // The Gray input is combinational from a binary counter and may glitch
  // Registering it here means only one bit can change between samples
  always_ff @(posedge src_clk or negedge src_arst_n) begin
    if (!src_arst_n) begin
      src_gray_q <= '0;
    end else begin
      src_gray_q <= src_count_gray;
    end
  end

  // ----------------------------------------
  // Destination domain
  // ----------------------------------------
  // Each stage gives a late-settling bit another full cycle to resolve
  always_ff @(posedge dst_clk or negedge dst_arst_n) begin
    if (!dst_arst_n) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= src_gray_q;
      for (int i = 1; i < NumStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Last stage is safe to decode in the destination domain
  assign dst_count_gray = sync_q[NumStages-1];

endmodule : cdc_fifo_gray_count_sync

`default_nettype wire

/* rtl/cdc_fifo_pkg.sv */
`default_nettype none

package cdc_fifo_pkg;

  // ----------------------------------------
  // FIFO sizes
  // ----------------------------------------
  // Depth stays a power of two so the Gray count wraps with a single bit change
  localparam int Depth = 8;
  localparam int Width = 32;
  localparam int AddrWidth = $clog2(Depth);
  // One extra bit tells a full FIFO from an empty one
  localparam int CountWidth = AddrWidth + 1;

  // ----------------------------------------
  // RAM port bundles
  // ----------------------------------------
  typedef struct packed {
    logic                 valid;
    logic [AddrWidth-1:0] addr;
    logic [Width-1:0]     data;
  } ram_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [AddrWidth-1:0] addr;
  } ram_rd_req_t;

  typedef struct packed {
    logic             valid;
    logic [Width-1:0] data;
  } ram_rd_rsp_t;

  // Binary to Gray, one bit flips per increment
  function automatic logic [CountWidth-1:0] bin2gray(input logic [CountWidth-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // Gray to binary, each bit folds in all the higher Gray bits
  function automatic logic [CountWidth-1:0] gray2bin(input logic [CountWidth-1:0] gray);
    logic [CountWidth-1:0] bin;
    bin[CountWidth-1] = gray[CountWidth-1];
    for (int i = CountWidth - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage : cdc_fifo_pkg

`default_nettype wire

/* rtl/cdc_fifo_pop_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_pop_ctrl #(
  parameter int RamReadLatency = 1
) (
  input  logic                                pop_clk,
  input  logic                                arst_n,

  // Pop interface
  input  logic                                pop_ready,
  output logic                                pop_valid,
  output logic [cdc_fifo_pkg::Width-1:0]      pop_data,

  // Status flags
  output logic                                pop_empty,
  output logic [cdc_fifo_pkg::CountWidth-1:0] pop_items,

  // RAM read port
  output cdc_fifo_pkg::ram_rd_req_t           ram_rd_req,
  input  cdc_fifo_pkg::ram_rd_rsp_t           ram_rd_rsp,

  // Counts crossing the domains
  input  logic [cdc_fifo_pkg::CountWidth-1:0] push_count_gray,
  output logic [cdc_fifo_pkg::CountWidth-1:0] pop_count_gray
);

  import cdc_fifo_pkg::*;

  // Room for one word per cycle of read latency plus the one on display
  localparam int StageDepth = RamReadLatency + 1;
  localparam int StageCntW  = $clog2(StageDepth + 1);

  // Push count as last seen through the synchronizer
  logic [CountWidth-1:0] push_count_bin;

  // Reads issued so far, low bits are the read address
  logic [CountWidth-1:0] rd_count_q;
  // Words handed out on the pop interface so far
  logic [CountWidth-1:0] pop_count_q;
  // Stored words not yet asked of the RAM
  logic [CountWidth-1:0] unread;

  // Staging buffer, entry 0 is the head of the queue
  logic [StageDepth-1:0][Width-1:0] stage_q;
  logic [StageDepth-1:0][Width-1:0] stage_next;
  logic [StageCntW-1:0]             stage_cnt_q;
  logic [StageCntW-1:0]             inflight_q;
  logic [StageCntW-1:0]             reserved;
  logic [StageCntW-1:0]             wr_idx;

  logic                  pop_beat;
  logic                  rd_issue;

  // ----------------------------------------
  // Counts and flags
  // ----------------------------------------
  assign push_count_bin = gray2bin(push_count_gray);
  assign unread         = push_count_bin - rd_count_q;
  // Items include words in flight and in the staging buffer
  assign pop_items      = push_count_bin - pop_count_q;
  assign pop_empty      = (pop_items == '0);
  assign pop_count_gray = bin2gray(pop_count_q);

  assign pop_valid = (stage_cnt_q != '0);
  assign pop_data  = stage_q[0];
  assign pop_beat  = pop_valid && pop_ready;

  // ----------------------------------------
  // Read issue
  // ----------------------------------------
  // Every read in flight holds a staging slot until its data lands
  // A pop in this cycle frees a slot, so the next read can go out at once
  assign reserved = stage_cnt_q + inflight_q;
  assign rd_issue = (unread != '0) && ((reserved < StageCntW'(StageDepth)) || pop_beat);

  always_comb begin
    ram_rd_req.valid = rd_issue;
    ram_rd_req.addr  = rd_count_q[AddrWidth-1:0];
  end

  always_ff @(posedge pop_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_count_q  <= '0;
      pop_count_q <= '0;
      inflight_q  <= '0;
      stage_cnt_q <= '0;
    end else begin
      if (rd_issue) begin
        rd_count_q <= rd_count_q + CountWidth'(1);
      end
      if (pop_beat) begin
        pop_count_q <= pop_count_q + CountWidth'(1);
      end
      // With zero latency the issue and the response cancel in the same cycle
      inflight_q  <= inflight_q + StageCntW'(rd_issue) - StageCntW'(ram_rd_rsp.valid);
      stage_cnt_q <= stage_cnt_q + StageCntW'(ram_rd_rsp.valid) - StageCntW'(pop_beat);
    end
  end

  // ----------------------------------------
  // Staging buffer
  // ----------------------------------------
  // Incoming data goes behind the last kept entry
  assign wr_idx = stage_cnt_q - StageCntW'(pop_beat);

  always_comb begin
    stage_next = stage_q;
    // A pop shifts everything one place toward the head
    if (pop_beat) begin
      for (int i = 0; i < StageDepth - 1; i++) begin
        stage_next[i] = stage_q[i+1];
      end
    end
    if (ram_rd_rsp.valid) begin
      stage_next[wr_idx] = ram_rd_rsp.data;
    end
  end

  // Payload only, validity lives in stage_cnt_q
  always_ff @(posedge pop_clk) begin
    stage_q <= stage_next;
  end

endmodule : cdc_fifo_pop_ctrl

`default_nettype wire

/* rtl/cdc_fifo_push_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_push_ctrl (
  input  logic                                push_clk,
  input  logic                                arst_n,

  // Push interface
  input  logic                                push_valid,
  input  logic [cdc_fifo_pkg::Width-1:0]      push_data,
  output logic                                push_ready,

  // Status flags
  output logic                                push_full,
  output logic [cdc_fifo_pkg::CountWidth-1:0] push_slots,

  // RAM write port
  output cdc_fifo_pkg::ram_wr_t               ram_wr,

  // Counts crossing the domains
  output logic [cdc_fifo_pkg::CountWidth-1:0] push_count_gray,
  input  logic [cdc_fifo_pkg::CountWidth-1:0] pop_count_gray
);

  import cdc_fifo_pkg::*;

  // Binary count of accepted words, the low bits are the write address
  logic [CountWidth-1:0] push_count_q;

  // Pop count as last seen through the synchronizer
  logic [CountWidth-1:0] pop_count_bin;

  // Words the push side believes are still stored
  logic [CountWidth-1:0] used;

  // Goes high once the local reset has been released
  logic                  ready_en_q;

  logic                  push_beat;

  // ----------------------------------------
  // Occupancy
  // ----------------------------------------
  // The synchronized pop count lags the real one
  // So full here is pessimistic and never lets a slot be overwritten
  assign pop_count_bin = gray2bin(pop_count_gray);
  assign used          = push_count_q - pop_count_bin;
  assign push_full     = (used == CountWidth'(Depth));
  assign push_slots    = CountWidth'(Depth) - used;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  // Ready waits one cycle after reset release before it may rise
  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
    end
  end

  assign push_ready = ready_en_q && !push_full;
  assign push_beat  = push_valid && push_ready;

  // Advance the write pointer on every accepted word
  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      push_count_q <= '0;
    end else if (push_beat) begin
      push_count_q <= push_count_q + CountWidth'(1);
    end
  end

  // ----------------------------------------
  // RAM write and count export
  // ----------------------------------------
  // The write fires on the very edge that accepts the word
  always_comb begin
    ram_wr.valid = push_beat;
    ram_wr.addr  = push_count_q[AddrWidth-1:0];
    ram_wr.data  = push_data;
  end

  // The synchronizer flops this in push_clk before it crosses
  assign push_count_gray = bin2gray(push_count_q);

endmodule : cdc_fifo_push_ctrl

`default_nettype wire

/* rtl/cdc_fifo_ram_1r1w.sv */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_ram_1r1w #(
  parameter int ReadLatency = 1
) (
  input  logic                      wr_clk,
  input  logic                      rd_clk,
  input  logic                      arst_n,
  input  cdc_fifo_pkg::ram_wr_t     ram_wr,
  input  cdc_fifo_pkg::ram_rd_req_t ram_rd_req,
  output cdc_fifo_pkg::ram_rd_rsp_t ram_rd_rsp
);

  import cdc_fifo_pkg::*;

  // Storage, written only in the push domain
  logic [Depth-1:0][Width-1:0] mem_q;

  always_ff @(posedge wr_clk) begin
    if (ram_wr.valid) begin
      mem_q[ram_wr.addr] <= ram_wr.data;
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------
  if (ReadLatency == 0) begin : g_rd_comb
    // Data comes back in the same pop cycle as the request
    assign ram_rd_rsp.valid = ram_rd_req.valid;
    assign ram_rd_rsp.data  = mem_q[ram_rd_req.addr];
  end else begin : g_rd_reg
    logic             rsp_valid_q;
    logic [Width-1:0] rsp_data_q;

    // Response valid follows the request by one pop cycle
    always_ff @(posedge rd_clk or negedge arst_n) begin
      if (!arst_n) begin
        rsp_valid_q <= 1'b0;
      end else begin
        rsp_valid_q <= ram_rd_req.valid;
      end
    end

    always_ff @(posedge rd_clk) begin
      if (ram_rd_req.valid) begin
        rsp_data_q <= mem_q[ram_rd_req.addr];
      end
    end

    assign ram_rd_rsp.valid = rsp_valid_q;
    assign ram_rd_rsp.data  = rsp_data_q;
  end

endmodule : cdc_fifo_ram_1r1w

`default_nettype wire
